//--- files.f
t04Pkg.sv
t04WbIf.sv
t04ScanTimer.sv
t04KeypadScan.sv
t04ScreenFsm.sv
t04ScreenBus.sv
t04Top.sv
t04TopTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the keypad to screen testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/100ps --top-module t04TopTb \
  -f files.f > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vt04TopTb > sim.log 2>&1 && status=0 || status=1
grep -q "Regression failed" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
[ "$status" -eq 0 ] || { echo "simulation stopped abnormally, see sim.log"; exit 1; }
echo "simulation passed"
exit 0

//--- t04TopTb.sv
`timescale 1ns/100ps

module t04TopTb;

  // one full four-column sweep of the keypad
  localparam int sweepCycles = t04Pkg::scanDiv * 4;
  // longest wait for any single event, in clock cycles
  localparam int waitLimit = 2000;
  // memory write command of the screen controller
  localparam t04Pkg::screenByteT memWriteCmd = 8'h2C;

  logic clk;
  logic rstN;
  t04Pkg::keyLineT row = 4'b1111;
  t04Pkg::keyLineT column;
  logic [4:0] button;
  logic screenCsx;
  logic screenDcx;
  logic screenWrx;
  t04Pkg::screenByteT screenData;

  // keypad model state
  logic pressed;
  t04Pkg::keyCodeT keySel;
  // expected screen writes, dcx above the byte
  logic [8:0] expQ[$];
  logic [31:0] lfsr;
  logic prevWrx = 1'b1;

  t04Top i_dut (
    .clk(clk),
    .rstN(rstN),
    .row(row),
    .column(column),
    .button(button),
    .screenCsx(screenCsx),
    .screenDcx(screenDcx),
    .screenWrx(screenWrx),
    .screenData(screenData)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic failNow(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkByte(input string name, input t04Pkg::screenByteT want,
                           input t04Pkg::screenByteT got);
    if (got !== want) begin
      failNow($sformatf("ERR %0t %s expected %h actual %h", $time, name, want, got));
    end
  endtask

  task automatic checkLine(input string name, input t04Pkg::keyLineT want,
                           input t04Pkg::keyLineT got);
    if (got !== want) begin
      failNow($sformatf("ERR %0t %s expected %b actual %b", $time, name, want, got));
    end
  endtask

  task automatic checkButton(input logic [4:0] want, input logic [4:0] got);
    if (got !== want) begin
      failNow($sformatf("ERR %0t button expected %h actual %h", $time, want, got));
    end
  endtask

  task automatic checkBit(input string name, input logic want, input logic got);
    if (got !== want) begin
      failNow($sformatf("ERR %0t %s expected %b actual %b", $time, name, want, got));
    end
  endtask

  // command byte with dcx low, then pixel byte with dcx high
  function automatic logic [17:0] refPair(input t04Pkg::keyCodeT key);
    refPair = {1'b0, memWriteCmd, 1'b1, key, key};
  endfunction

  // galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    lfsrNext = s >> 1;
    if (s[0]) lfsrNext = lfsrNext ^ 32'h80200003;
  endfunction

  // one lfsr step per bit taken
  task automatic randBits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      val = (val << 1) | int'(lfsr[0]);
      lfsr = lfsrNext(lfsr);
    end
  endtask

  // row r pulled low while the key's column c is driven low
  function automatic t04Pkg::keyLineT rowFor(input t04Pkg::keyLineT col, input logic down,
                                             input t04Pkg::keyCodeT key);
    rowFor = 4'b1111;
    if (down && !col[key[1:0]]) rowFor[key[3:2]] = 1'b0;
  endfunction

  always @(posedge clk) begin
    row <= rowFor(column, pressed, keySel);
  end

  // screen monitor, a write lands on the rising wrx edge while csx is low
  always @(negedge clk) begin
    logic [8:0] want;
    if (rstN && !prevWrx && screenWrx && !screenCsx) begin
      if (expQ.size() == 0) begin
        failNow($sformatf("unexpected screen write of %h at %0t", screenData, $time));
      end else begin
        want = expQ.pop_front();
        checkBit("screenDcx", want[8], screenDcx);
        checkByte("screenData", want[7:0], screenData);
      end
    end
    prevWrx = screenWrx;
  end

  task automatic expectKey(input t04Pkg::keyCodeT key);
    logic [17:0] pair;
    pair = refPair(key);
    expQ.push_back(pair[17:9]);
    expQ.push_back(pair[8:0]);
  endtask

  task automatic pressKey(input t04Pkg::keyCodeT key);
    @(posedge clk);
    keySel <= key;
    pressed <= 1'b1;
  endtask

  task automatic releaseKey();
    @(posedge clk);
    pressed <= 1'b0;
  endtask

  task automatic waitHeld(input logic level, input string what);
    int n;
    n = 0;
    while (button[4] !== level && n < waitLimit) begin
      @(negedge clk);
      n++;
    end
    if (button[4] !== level) failNow($sformatf("timeout waiting for the %s", what));
  endtask

  task automatic waitDrained(input string what);
    int n;
    n = 0;
    while (expQ.size() != 0 && n < waitLimit) begin
      @(negedge clk);
      n++;
    end
    if (expQ.size() != 0) failNow($sformatf("timeout waiting for the %s", what));
  endtask

  // sixteen column steps, each one scan period after the last
  task automatic checkColumnWalk();
    t04Pkg::keyLineT last;
    t04Pkg::keyLineT want;
    int n;
    last = column;
    for (int step = 0; step < 16; step++) begin
      // low line walks up from column 0 and wraps after column 3
      want = ~(t04Pkg::keyLineT'(1) << ((step + 1) % 4));
      n = 0;
      do begin
        @(negedge clk);
        n++;
      end while (column === last && n < waitLimit);
      if (column === last) failNow("timeout waiting for the column drive to move on");
      checkLine("column", want, column);
      if (step > 0 && n != t04Pkg::scanDiv) begin
        failNow($sformatf("column moved after %0d cycles instead of %0d", n, t04Pkg::scanDiv));
      end
      last = column;
    end
  endtask

  // one held key, one byte pair, then button follows press and release
  task automatic pressAndCheck(input t04Pkg::keyCodeT key);
    expectKey(key);
    pressKey(key);
    waitHeld(1'b1, "key press to be accepted");
    waitDrained("screen write pair");
    checkButton({1'b1, key}, button);
    releaseKey();
    waitHeld(1'b0, "key release to be accepted");
    checkButton({1'b0, key}, button);
    repeat (sweepCycles) @(posedge clk);
  endtask

  initial begin
    int holdSweeps;
    int gapSweeps;
    int jitter;
    int val;
    t04Pkg::keyCodeT key;
    rstN = 1'b0;
    pressed = 1'b0;
    keySel = '0;
    lfsr = 32'h07928101;
    repeat (4) @(posedge clk);
    rstN <= 1'b1;
    @(negedge clk);
    // idle outputs straight after reset
    checkLine("column", 4'b1110, column);
    checkBit("screenCsx", 1'b1, screenCsx);
    checkBit("screenWrx", 1'b1, screenWrx);
    checkButton(5'd0, button);
    checkColumnWalk();
    for (int k = 0; k < 16; k++) begin
      pressAndCheck(4'(k));
    end
    // short bounces, each caught by one sweep at most
    for (int b = 0; b < 3; b++) begin
      pressKey(4'd9);
      repeat (40) @(posedge clk);
      releaseKey();
      repeat (100) @(posedge clk);
    end
    repeat (6 * sweepCycles) @(posedge clk);
    @(negedge clk);
    checkButton({1'b0, 4'hF}, button);
    // random keys, holds and gaps; jitter moves the scan phase
    for (int i = 0; i < 12; i++) begin
      randBits(4, val);
      key = 4'(val);
      randBits(3, holdSweeps);
      randBits(2, gapSweeps);
      randBits(6, jitter);
      expectKey(key);
      pressKey(key);
      repeat ((5 + holdSweeps) * sweepCycles) @(posedge clk);
      releaseKey();
      repeat ((5 + gapSweeps) * sweepCycles + jitter) @(posedge clk);
    end
    waitDrained("last random write pair");
    if (expQ.size() == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      failNow("expected screen writes never appeared");
    end
  end

endmodule

//--- t04Top.sv
`timescale 1ns/100ps

module t04Top (
  input  logic clk,
  input  logic rstN,
  input  t04Pkg::keyLineT row,
  output t04Pkg::keyLineT column,
  output logic [4:0] button,
  output logic screenCsx,
  output logic screenDcx,
  output logic screenWrx,
  output t04Pkg::screenByteT screenData
);

  logic scanTick;
  logic keyValid;
  logic keyTaken;
  logic keyHeld;
  t04Pkg::keyCodeT keyCode;

  // sequencer to screen pins
  t04WbIf wb ();

  t04ScanTimer iScanTimer (
    .clk(clk),
    .rstN(rstN),
    .scanTick(scanTick)
  );

  t04KeypadScan iKeypadScan (
    .clk(clk),
    .rstN(rstN),
    .scanTick(scanTick),
    .row(row),
    .column(column),
    .keyValid(keyValid),
    .keyCode(keyCode),
    .keyTaken(keyTaken),
    .keyHeld(keyHeld)
  );

  t04ScreenFsm iScreenFsm (
    .clk(clk),
    .rstN(rstN),
    .keyValid(keyValid),
    .keyCode(keyCode),
    .keyTaken(keyTaken),
    .bus(wb.master)
  );

  t04ScreenBus iScreenBus (
    .clk(clk),
    .rstN(rstN),
    .bus(wb.slave),
    .screenCsx(screenCsx),
    .screenDcx(screenDcx),
    .screenWrx(screenWrx),
    .screenData(screenData)
  );

  // held flag above the last accepted key
  assign button = {keyHeld, keyCode};

endmodule

//--- t04ScreenBus.sv
`timescale 1ns/100ps

module t04ScreenBus (
  input  logic clk,
  input  logic rstN,
  t04WbIf.slave bus,
  output logic screenCsx,
  output logic screenDcx,
  output logic screenWrx,
  output t04Pkg::screenByteT screenData
);

  // screen cycle in progress, including the ack cycle
  logic busy;
  t04Pkg::phaseCntT phase;
  logic startCycle;

  assign startCycle = !busy && bus.cyc && bus.stb && bus.we;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      busy <= 1'b0;
      phase <= '0;
      screenCsx <= 1'b1;
      screenWrx <= 1'b1;
      bus.ack <= 1'b0;
    end else if (!busy) begin
      // csx and wrx fall together
      if (startCycle) begin
        busy <= 1'b1;
        phase <= '0;
        screenCsx <= 1'b0;
        screenWrx <= 1'b0;
      end
    end else begin
      phase <= phase + 1'b1;
      // rising wrx latches the byte in the controller
      if (phase == t04Pkg::wrRiseAt) screenWrx <= 1'b1;
      // ack in the last high cycle, chip deselected with it
      if (phase == t04Pkg::ackAt) begin
        bus.ack <= 1'b1;
        screenCsx <= 1'b1;
      end
      if (bus.ack) begin
        bus.ack <= 1'b0;
        busy <= 1'b0;
      end
    end
  end

  // byte and d/c held for the whole chip select window
  always_ff @(posedge clk) begin
    if (startCycle) begin
      screenDcx <= bus.adr;
      screenData <= bus.datW;
    end
  end

  dataStableWhileSelected: assert property (
    @(posedge clk) disable iff (!rstN)
    !screenCsx |=> screenCsx || $stable(screenData)
  );

endmodule

//--- t04ScreenFsm.sv
`timescale 1ns/100ps

module t04ScreenFsm (
  input  logic clk,
  input  logic rstN,
  input  logic keyValid,
  input  t04Pkg::keyCodeT keyCode,
  output logic keyTaken,
  t04WbIf.master bus
);

  t04Pkg::screenFsmStateT state;
  // key being written
  t04Pkg::keyCodeT codeReg;

  // write-only master
  assign bus.we = bus.cyc;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= t04Pkg::idle;
      keyTaken <= 1'b0;
      bus.cyc <= 1'b0;
      bus.stb <= 1'b0;
    end else begin
      keyTaken <= 1'b0;
      case (state)
        t04Pkg::idle: begin
          // command cycle starts together with the handshake back
          if (keyValid) begin
            state <= t04Pkg::sendCmd;
            keyTaken <= 1'b1;
            bus.cyc <= 1'b1;
            bus.stb <= 1'b1;
          end
        end
        t04Pkg::sendCmd: begin
          if (bus.ack) begin
            state <= t04Pkg::sendData;
            bus.cyc <= 1'b0;
            bus.stb <= 1'b0;
          end
        end
        t04Pkg::sendData: begin
          // one idle bus cycle between the two transfers
          if (bus.ack) begin
            state <= t04Pkg::done;
            bus.cyc <= 1'b0;
            bus.stb <= 1'b0;
          end else if (!bus.cyc) begin
            bus.cyc <= 1'b1;
            bus.stb <= 1'b1;
          end
        end
        t04Pkg::done: begin
          state <= t04Pkg::idle;
        end
        default: begin
          state <= t04Pkg::idle;
        end
      endcase
    end
  end

  // address and data, stable from before stb until ack
  always_ff @(posedge clk) begin
    if (state == t04Pkg::idle && keyValid) begin
      codeReg <= keyCode;
      bus.adr <= 1'b0;
      bus.datW <= t04Pkg::cmdMemWrite;
    end else if (state == t04Pkg::sendCmd && bus.ack) begin
      // pixel is the key code in both nibbles
      bus.adr <= 1'b1;
      bus.datW <= {codeReg, codeReg};
    end
  end

  stbWithinCyc: assert property (
    @(posedge clk) disable iff (!rstN)
    bus.stb |-> bus.cyc
  );

endmodule

//--- t04KeypadScan.sv
`timescale 1ns/100ps

module t04KeypadScan (
  input  logic clk,
  input  logic rstN,
  input  logic scanTick,
  input  t04Pkg::keyLineT row,
  output t04Pkg::keyLineT column,
  output logic keyValid,
  output t04Pkg::keyCodeT keyCode,
  input  logic keyTaken,
  output logic keyHeld
);

  // row synchronizer
  t04Pkg::keyLineT rowMeta;
  t04Pkg::keyLineT rowSync;
  // index of the column driven low
  logic [1:0] colIdx;
  // first hit within the current sweep
  logic sweepFound;
  t04Pkg::keyCodeT sweepCode;
  // key under debounce and its sweep counts
  t04Pkg::keyCodeT candCode;
  t04Pkg::debCntT pressCnt;
  t04Pkg::debCntT relCnt;
  // combinational sweep evaluation
  logic hitNow;
  t04Pkg::keyCodeT hitCode;
  logic sweepEnd;
  logic endFound;
  t04Pkg::keyCodeT endCode;
  t04Pkg::debCntT pressNext;
  t04Pkg::debCntT relNext;
  logic pressOk;
  logic releaseOk;

  always_comb begin
    hitNow = (rowSync != '1);
    hitCode = {2'd3, colIdx};
    // scan down so the lowest low row wins
    for (int r = 3; r >= 0; r--) begin
      if (!rowSync[r]) hitCode = {2'(r), colIdx};
    end
    // last column sampled on this tick closes the sweep
    sweepEnd = scanTick && (colIdx == 2'd3);
    endFound = sweepFound || hitNow;
    endCode = sweepFound ? sweepCode : hitCode;
    // press count, restarts on a different key
    if (!endFound) begin
      pressNext = '0;
    end else if (endCode == candCode && pressCnt != '0) begin
      pressNext = (pressCnt == t04Pkg::debounceTop) ? pressCnt : pressCnt + 1'b1;
    end else begin
      pressNext = t04Pkg::debCntT'(1);
    end
    // release count, any hit restarts it
    if (endFound) begin
      relNext = '0;
    end else begin
      relNext = (relCnt == t04Pkg::debounceTop) ? relCnt : relCnt + 1'b1;
    end
    pressOk = sweepEnd && (pressNext == t04Pkg::debounceTop) && !keyHeld;
    releaseOk = sweepEnd && (relNext == t04Pkg::debounceTop);
  end

  // payload, only read when the matching flag or count says so
  always_ff @(posedge clk) begin
    rowMeta <= row;
    rowSync <= rowMeta;
    if (scanTick && !sweepFound && hitNow) sweepCode <= hitCode;
    if (sweepEnd && endFound) candCode <= endCode;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      column <= 4'b1110;
      colIdx <= 2'd0;
      sweepFound <= 1'b0;
      pressCnt <= '0;
      relCnt <= '0;
      keyHeld <= 1'b0;
      keyValid <= 1'b0;
      keyCode <= '0;
    end else begin
      // rows sampled on this tick, then the column moves on
      if (scanTick) begin
        column <= {column[2:0], column[3]};
        colIdx <= colIdx + 2'd1;
        if (sweepEnd) begin
          sweepFound <= 1'b0;
        end else if (hitNow) begin
          sweepFound <= 1'b1;
        end
      end
      if (sweepEnd) begin
        pressCnt <= pressNext;
        relCnt <= relNext;
      end
      if (pressOk) begin
        keyHeld <= 1'b1;
      end else if (releaseOk) begin
        keyHeld <= 1'b0;
      end
      // a pending event blocks new presses
      if (keyTaken) begin
        keyValid <= 1'b0;
      end else if (pressOk && !keyValid) begin
        keyValid <= 1'b1;
        keyCode <= endCode;
      end
    end
  end

  // exactly one column driven low at any time
  columnOneHot: assert property (
    @(posedge clk) disable iff (!rstN)
    $onehot(~column)
  );

endmodule

//--- t04ScanTimer.sv
`timescale 1ns/100ps

module t04ScanTimer (
  input  logic clk,
  input  logic rstN,
  output logic scanTick
);

  // counts down to zero, then reloads
  t04Pkg::scanCntT divCnt;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      divCnt <= t04Pkg::scanReload;
    end else if (divCnt == '0) begin
      divCnt <= t04Pkg::scanReload;
    end else begin
      divCnt <= divCnt - 1'b1;
    end
  end

  // one cycle pulse at the bottom of the count
  assign scanTick = (divCnt == '0);

  // scanner expects isolated ticks, a double tick would skip a column
  tickIsPulse: assert property (
    @(posedge clk) disable iff (!rstN)
    scanTick |=> !scanTick
  );

endmodule

//--- t04WbIf.sv
`timescale 1ns/100ps

// wishbone classic, write only, one byte wide
interface t04WbIf;
  logic cyc;
  logic stb;
  logic we;
  t04Pkg::busAdrT adr;
  t04Pkg::screenByteT datW;
  logic ack;

  // sequencer side
  modport master (
    output cyc,
    output stb,
    output we,
    output adr,
    output datW,
    input  ack
  );

  // screen pin side
  modport slave (
    input  cyc,
    input  stb,
    input  we,
    input  adr,
    input  datW,
    output ack
  );
endinterface

//--- t04Pkg.sv
package t04Pkg;

  // clock cycles between scan ticks, kept short for simulation
  localparam int scanDiv = 16;
  // full sweeps that must agree before a press or release counts
  localparam int debounceScans = 3;
  // write strobe low time in cycles
  localparam int wrLowCycles = 2;
  // write strobe high time before ack
  localparam int wrHighCycles = 2;

  // key number, row * 4 + column
  typedef logic [3:0] keyCodeT;
  // one line per matrix row or column, active low
  typedef logic [3:0] keyLineT;
  // byte on the screen data pins
  typedef logic [7:0] screenByteT;
  // 0 selects a command byte, 1 a data byte
  typedef logic busAdrT;

  // screen controller memory write command
  localparam screenByteT cmdMemWrite = 8'h2C;

  // scan divider count
  typedef logic [$clog2(scanDiv)-1:0] scanCntT;
  localparam scanCntT scanReload = scanCntT'(scanDiv - 1);

  // debounce sweep counters, saturate at debounceScans
  typedef logic [$clog2(debounceScans + 1)-1:0] debCntT;
  localparam debCntT debounceTop = debCntT'(debounceScans);

  // write strobe phase within one screen cycle
  typedef logic [$clog2(wrLowCycles + wrHighCycles)-1:0] phaseCntT;
  // last low phase, wrx rises after it
  localparam phaseCntT wrRiseAt = phaseCntT'(wrLowCycles - 1);
  // phase after which ack and csx rise
  localparam phaseCntT ackAt = phaseCntT'(wrLowCycles + wrHighCycles - 2);

  // key to screen sequencer
  typedef enum logic [1:0] {
    idle,
    sendCmd,
    sendData,
    done
  } screenFsmStateT;

endpackage
